// ==== Makefile ====
TOP := gamma_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== hw/gamma_ctrl.sv ====
`timescale 1ns/1ps
`include "gamma_defines.svh"

module gamma_ctrl (
  input  logic                     I_clk,
  input  logic                     I_rst_n,
  input  logic [`GAMMA_CODE_W-1:0] gamma_code,
  input  logic                     in_valid,
  input  logic                     in_sof,
  input  logic                     in_eol,
  output gamma_pkg::curve_t        curve,
  output logic                     stage_en_round,
  output logic                     stage_en_clamp,
  output logic                     out_valid,
  output logic                     out_sof,
  output logic                     out_eol
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame curve
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  gamma_pkg::curve_t frame_curve;
  logic              frame_start;

  assign frame_start = in_valid && in_sof;

  // The code is only sampled on a valid frame-start beat, so a change in
  // the middle of a frame waits for the next frame
  always_ff @(posedge I_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      frame_curve <= gamma_pkg::CURVE_2_2;
    end else if (frame_start) begin
      frame_curve <= gamma_pkg::decode_code(gamma_code);
    end
  end

  // The frame-start beat itself already uses the new curve
  assign curve = frame_start ? gamma_pkg::decode_code(gamma_code) : frame_curve;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Valid and sideband pipeline
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [`GAMMA_LATENCY-1:0] valid_pipe;
  logic [`GAMMA_LATENCY-1:0] sof_pipe;
  logic [`GAMMA_LATENCY-1:0] eol_pipe;

  always_ff @(posedge I_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      valid_pipe <= '0;
      sof_pipe   <= '0;
      eol_pipe   <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`GAMMA_LATENCY-2:0], in_valid};
      sof_pipe   <= {sof_pipe[`GAMMA_LATENCY-2:0], in_sof};
      eol_pipe   <= {eol_pipe[`GAMMA_LATENCY-2:0], in_eol};
    end
  end

  // Tap 0 marks a beat in the lookup register, tap 1 one in the round register
  assign stage_en_round = valid_pipe[0];
  assign stage_en_clamp = valid_pipe[1];

  assign out_valid = valid_pipe[`GAMMA_LATENCY-1];
  assign out_sof   = sof_pipe[`GAMMA_LATENCY-1];
  assign out_eol   = eol_pipe[`GAMMA_LATENCY-1];

endmodule

// ==== hw/gamma_lut.sv ====
`timescale 1ns/1ps
`include "gamma_defines.svh"

module gamma_lut (
  input  logic                   I_clk,
  input  logic                   I_rst_n,
  input  gamma_pkg::curve_t      curve,
  input  gamma_pkg::sample_t     sample,
  output gamma_pkg::curve_word_t value
);

  localparam int curve_count = 4;
  localparam int entry_count = 2 ** `GAMMA_SAMPLE_W;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Curve tables
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Every entry is a constant worked out while the design elaborates,
  // so the tables reduce to ROM logic
  gamma_pkg::curve_word_t rom [curve_count][entry_count];

  for (genvar c = 0; c < curve_count; c++) begin : g_curve
    for (genvar x = 0; x < entry_count; x++) begin : g_entry
      localparam gamma_pkg::curve_word_t lut_entry =
        gamma_pkg::curve_value(gamma_pkg::curve_t'(c), x);

      assign rom[c][x] = lut_entry;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Registered read
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Runs every cycle; the requant stages decide which results to keep
  always_ff @(posedge I_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      value <= '0;
    end else begin
      value <= rom[curve][sample];
    end
  end

endmodule

// ==== hw/gamma_pkg.sv ====
`include "gamma_defines.svh"

package gamma_pkg;

  // One colour sample at the stream boundary
  typedef logic [`GAMMA_SAMPLE_W-1:0] sample_t;

  // One entry of a 12-bit gamma curve
  typedef logic [`GAMMA_LUT_W-1:0] curve_word_t;

  // The curves that the lookup holds
  typedef enum logic [1:0] {
    CURVE_0_8 = 2'd0,
    CURVE_1_6 = 2'd1,
    CURVE_2_2 = 2'd2,
    CURVE_2_6 = 2'd3
  } curve_t;

  // Codes without a curve of their own fall back to 2.2
  function automatic curve_t decode_code(input logic [`GAMMA_CODE_W-1:0] code);
    case (code)
      `GAMMA_CODE_08: decode_code = CURVE_0_8;
      `GAMMA_CODE_16: decode_code = CURVE_1_6;
      `GAMMA_CODE_26: decode_code = CURVE_2_6;
      default:        decode_code = CURVE_2_2;
    endcase
  endfunction

  // L(x) = round(4095 * (x / 255) ^ (10 / code))
  // Only evaluated while the lookup tables are being built
  function automatic curve_word_t curve_value(input curve_t curve, input int x);
    real code;
    real level;
    case (curve)
      CURVE_0_8: code = `GAMMA_CODE_08;
      CURVE_1_6: code = `GAMMA_CODE_16;
      CURVE_2_6: code = `GAMMA_CODE_26;
      default:   code = `GAMMA_CODE_22;
    endcase
    level = 4095.0 * ((real'(x) / 255.0) ** (10.0 / code));
    curve_value = curve_word_t'($rtoi(level + 0.5));
  endfunction

endpackage

// ==== hw/gamma_requant.sv ====
`timescale 1ns/1ps
`include "gamma_defines.svh"

module gamma_requant (
  input  logic                   I_clk,
  input  logic                   I_rst_n,
  input  logic                   stage_en_round,
  input  logic                   stage_en_clamp,
  input  gamma_pkg::curve_word_t values [`GAMMA_SAMPLES],
  output gamma_pkg::sample_t     samples [`GAMMA_SAMPLES]
);

  // Dropping four bits takes 12-bit curve values to 8-bit samples
  localparam int drop_w = `GAMMA_LUT_W - `GAMMA_SAMPLE_W;
  localparam int sum_w  = `GAMMA_LUT_W + 1;

  // Half of one output step, added before the truncating divide
  localparam logic [sum_w-1:0] half_step = sum_w'(2 ** (drop_w - 1));

  // Largest sample value, used when the rounded result overflows
  localparam gamma_pkg::sample_t sample_max = '1;

  logic [sum_w-1:0] round_q [`GAMMA_SAMPLES];

  for (genvar i = 0; i < `GAMMA_SAMPLES; i++) begin : g_sample

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One extra bit keeps the carry out of 4095 + 8
    always_ff @(posedge I_clk or negedge I_rst_n) begin
      if (!I_rst_n) begin
        round_q[i] <= '0;
      end else if (stage_en_round) begin
        round_q[i] <= {1'b0, values[i]} + half_step;
      end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Divide and clamp stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The top bit of the sum is set exactly when the quotient exceeds 255
    always_ff @(posedge I_clk or negedge I_rst_n) begin
      if (!I_rst_n) begin
        samples[i] <= '0;
      end else if (stage_en_clamp) begin
        if (round_q[i][sum_w-1]) begin
          samples[i] <= sample_max;
        end else begin
          samples[i] <= round_q[i][sum_w-2:drop_w];
        end
      end
    end

  end

endmodule

// ==== hw/gamma_top.sv ====
`timescale 1ns/1ps
`include "gamma_defines.svh"

module gamma_top (
  input  logic                     I_clk,
  input  logic                     I_rst_n,
  input  logic [`GAMMA_CODE_W-1:0] gamma_code,
  input  logic                     in_valid,
  input  logic                     in_sof,
  input  logic                     in_eol,
  input  logic [`GAMMA_DATA_W-1:0] in_data,
  output logic                     out_valid,
  output logic                     out_sof,
  output logic                     out_eol,
  output logic [`GAMMA_DATA_W-1:0] out_data
);

  gamma_pkg::curve_t      curve;
  logic                   stage_en_round;
  logic                   stage_en_clamp;
  gamma_pkg::sample_t     sample_in  [`GAMMA_SAMPLES];
  gamma_pkg::curve_word_t lut_value  [`GAMMA_SAMPLES];
  gamma_pkg::sample_t     sample_out [`GAMMA_SAMPLES];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  gamma_ctrl u_ctrl (
    .I_clk          (I_clk),
    .I_rst_n        (I_rst_n),
    .gamma_code     (gamma_code),
    .in_valid       (in_valid),
    .in_sof         (in_sof),
    .in_eol         (in_eol),
    .curve          (curve),
    .stage_en_round (stage_en_round),
    .stage_en_clamp (stage_en_clamp),
    .out_valid      (out_valid),
    .out_sof        (out_sof),
    .out_eol        (out_eol)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Per-sample lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Sample k sits at bits 8k upwards; blue, green, red from the low end
  // of each pixel, and the same packing is used on the way out
  for (genvar k = 0; k < `GAMMA_SAMPLES; k++) begin : g_lane
    assign sample_in[k] = in_data[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W];

    gamma_lut u_lut (
      .I_clk   (I_clk),
      .I_rst_n (I_rst_n),
      .curve   (curve),
      .sample  (sample_in[k]),
      .value   (lut_value[k])
    );

    assign out_data[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W] = sample_out[k];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Requantization
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  gamma_requant u_requant (
    .I_clk          (I_clk),
    .I_rst_n        (I_rst_n),
    .stage_en_round (stage_en_round),
    .stage_en_clamp (stage_en_clamp),
    .values         (lut_value),
    .samples        (sample_out)
  );

endmodule

// ==== include/gamma_defines.svh ====
`ifndef GAMMA_DEFINES_SVH
`define GAMMA_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Four RGB888 pixels travel in every beat
`define GAMMA_PIXELS 4
`define GAMMA_CHANNELS 3
`define GAMMA_SAMPLES (`GAMMA_PIXELS * `GAMMA_CHANNELS)

`define GAMMA_SAMPLE_W 8
`define GAMMA_LUT_W 12
`define GAMMA_DATA_W (`GAMMA_SAMPLES * `GAMMA_SAMPLE_W)

// Lookup, round and clamp registers
`define GAMMA_LATENCY 3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Gamma codes, ten times gamma
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define GAMMA_CODE_W 5
`define GAMMA_CODE_08 5'd8
`define GAMMA_CODE_16 5'd16
`define GAMMA_CODE_22 5'd22
`define GAMMA_CODE_26 5'd26

`endif

// ==== tb.f ====
+incdir+include
hw/gamma_pkg.sv
hw/gamma_ctrl.sv
hw/gamma_lut.sv
hw/gamma_requant.sv
hw/gamma_top.sv
tests/gamma_clock.sv
tests/gamma_checker.sv
tests/gamma_tb.sv

// ==== tests/gamma_checker.sv ====
`timescale 1ns/1ps
`include "gamma_defines.svh"

module gamma_checker (
  input logic                     I_clk,
  input logic                     I_rst_n,
  input logic                     in_valid,
  input logic                     in_sof,
  input logic                     in_eol,
  input logic                     out_valid,
  input logic                     out_sof,
  input logic                     out_eol,
  input logic [`GAMMA_DATA_W-1:0] out_data
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fixed pipeline latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_valid_latency : assert property (@(posedge I_clk) disable iff (!I_rst_n)
    out_valid == $past(in_valid, `GAMMA_LATENCY))
    else $error("out_valid does not match in_valid from three cycles earlier");

  a_sof_latency : assert property (@(posedge I_clk) disable iff (!I_rst_n)
    out_sof == $past(in_sof, `GAMMA_LATENCY))
    else $error("out_sof does not match in_sof from three cycles earlier");

  a_eol_latency : assert property (@(posedge I_clk) disable iff (!I_rst_n)
    out_eol == $past(in_eol, `GAMMA_LATENCY))
    else $error("out_eol does not match in_eol from three cycles earlier");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output hold between beats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The clamp register only loads on the edge that raises out_valid
  a_data_hold : assert property (@(posedge I_clk) disable iff (!I_rst_n)
    !out_valid |-> $stable(out_data))
    else $error("out_data changed while out_valid was low");

endmodule

// ==== tests/gamma_clock.sv ====
`timescale 1ns/1ps

module gamma_clock (
  output logic I_clk,
  output logic I_rst_n
);

  localparam int half_period = 20;
  localparam int reset_cycles = 2;

  initial begin
    I_clk = 1'b0;
    forever #half_period I_clk = ~I_clk;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    I_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge I_clk);
    @(negedge I_clk);
    I_rst_n = 1'b1;
  end

endmodule

// ==== tests/gamma_tb.sv ====
`timescale 1ns/1ps
`include "gamma_defines.svh"

module gamma_tb;

  localparam int clock_period = 40;
  localparam int reset_cycles = 2;

  typedef struct packed {
    logic                     valid;
    logic                     sof;
    logic                     eol;
    logic [`GAMMA_CODE_W-1:0] code;
    logic                     use_random;
    logic [`GAMMA_DATA_W-1:0] data;
    gamma_pkg::curve_t        curve;
  } row_t;

  typedef struct packed {
    logic                     valid;
    logic                     sof;
    logic                     eol;
    logic [`GAMMA_DATA_W-1:0] data;
  } beat_t;

  logic                     I_clk;
  logic                     I_rst_n;
  logic [`GAMMA_CODE_W-1:0] gamma_code;
  logic                     in_valid;
  logic                     in_sof;
  logic                     in_eol;
  logic [`GAMMA_DATA_W-1:0] in_data;
  logic                     out_valid;
  logic                     out_sof;
  logic                     out_eol;
  logic [`GAMMA_DATA_W-1:0] out_data;

  row_t        rows [$];
  beat_t       expect_q [$];
  logic [15:0] lfsr_state;
  logic        table_ready = 1'b0;

  gamma_clock u_clock (
    .I_clk   (I_clk),
    .I_rst_n (I_rst_n)
  );

  gamma_top dut (
    .I_clk      (I_clk),
    .I_rst_n    (I_rst_n),
    .gamma_code (gamma_code),
    .in_valid   (in_valid),
    .in_sof     (in_sof),
    .in_eol     (in_eol),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_sof    (out_sof),
    .out_eol    (out_eol),
    .out_data   (out_data)
  );

  bind gamma_top gamma_checker u_checker (
    .I_clk     (I_clk),
    .I_rst_n   (I_rst_n),
    .in_valid  (in_valid),
    .in_sof    (in_sof),
    .in_eol    (in_eol),
    .out_valid (out_valid),
    .out_sof   (out_sof),
    .out_eol   (out_eol),
    .out_data  (out_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random data and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Fibonacci LFSR over x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
  endfunction

  task automatic random_word(output logic [`GAMMA_DATA_W-1:0] word);
    for (int i = 0; i < `GAMMA_DATA_W; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word[i] = lfsr_state[0];
    end
  endtask

  // Curve entry followed by round-half-up to 8 bits and a clamp at 255
  function automatic gamma_pkg::sample_t expected_sample(input gamma_pkg::curve_t curve,
                                                         input gamma_pkg::sample_t x);
    real gamma_x10;
    int  level;
    int  quotient;
    case (curve)
      gamma_pkg::CURVE_0_8: gamma_x10 = 8.0;
      gamma_pkg::CURVE_1_6: gamma_x10 = 16.0;
      gamma_pkg::CURVE_2_6: gamma_x10 = 26.0;
      default:              gamma_x10 = 22.0;
    endcase
    level = $rtoi(4095.0 * ((real'(x) / 255.0) ** (10.0 / gamma_x10)) + 0.5);
    quotient = (level + 8) / 16;
    if (quotient > 255) begin
      quotient = 255;
    end
    return gamma_pkg::sample_t'(quotient);
  endfunction

  function automatic logic [`GAMMA_DATA_W-1:0] expected_word(
    input gamma_pkg::curve_t curve, input logic [`GAMMA_DATA_W-1:0] data);
    logic [`GAMMA_DATA_W-1:0] word;
    for (int k = 0; k < `GAMMA_SAMPLES; k++) begin
      word[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W] =
        expected_sample(curve, data[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W]);
    end
    return word;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_sample(input string name, input gamma_pkg::sample_t expected,
                              input gamma_pkg::sample_t actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Sample mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s expected %0b, got %0b", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Flag mismatch");
    end
  endtask

  task automatic check_beat(input beat_t beat);
    check_flag("out_valid", beat.valid, out_valid);
    check_flag("out_sof", beat.sof, out_sof);
    check_flag("out_eol", beat.eol, out_eol);
    // Data only carries meaning on a valid beat
    if (beat.valid) begin
      for (int k = 0; k < `GAMMA_SAMPLES; k++) begin
        check_sample($sformatf("out_data sample %0d", k),
                     beat.data[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W],
                     out_data[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W]);
      end
    end
  endtask

  task automatic check_reset_state();
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("out_sof", 1'b0, out_sof);
    check_flag("out_eol", 1'b0, out_eol);
    for (int k = 0; k < `GAMMA_SAMPLES; k++) begin
      check_sample($sformatf("out_data sample %0d", k), '0,
                   out_data[k*`GAMMA_SAMPLE_W +: `GAMMA_SAMPLE_W]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic add_row(input logic valid, input logic sof, input logic eol,
                         input logic [`GAMMA_CODE_W-1:0] code, input logic use_random,
                         input logic [`GAMMA_DATA_W-1:0] data, input gamma_pkg::curve_t curve);
    rows.push_back('{valid, sof, eol, code, use_random, data, curve});
  endtask

  task automatic add_gap(input int cycles);
    repeat (cycles) begin
      add_row(1'b0, 1'b0, 1'b0, `GAMMA_CODE_22, 1'b0, '0, gamma_pkg::CURVE_2_2);
    end
  endtask

  task automatic build_table();
    // No frame start yet, so the reset curve holds whatever the code says
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_08, 1'b0, {6{16'h00FF}}, gamma_pkg::CURVE_2_2);
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_08, 1'b0, 96'h0B0A09080706050403020100,
            gamma_pkg::CURVE_2_2);
    add_row(1'b1, 1'b0, 1'b1, `GAMMA_CODE_26, 1'b1, '0, gamma_pkg::CURVE_2_2);
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_16, 1'b1, '0, gamma_pkg::CURVE_2_2);
    // Frame on 0.8 with a code change in the middle
    add_row(1'b1, 1'b1, 1'b0, `GAMMA_CODE_08, 1'b1, '0, gamma_pkg::CURVE_0_8);
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_22, 1'b1, '0, gamma_pkg::CURVE_0_8);
    add_row(1'b1, 1'b0, 1'b1, `GAMMA_CODE_22, 1'b0, 96'h807F403F201F100F08070201,
            gamma_pkg::CURVE_0_8);
    add_gap(2);
    // Frame on 1.6 with gaps inside it
    add_row(1'b1, 1'b1, 1'b0, `GAMMA_CODE_16, 1'b1, '0, gamma_pkg::CURVE_1_6);
    add_gap(1);
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_26, 1'b1, '0, gamma_pkg::CURVE_1_6);
    add_row(1'b1, 1'b0, 1'b1, `GAMMA_CODE_08, 1'b1, '0, gamma_pkg::CURVE_1_6);
    // A single-beat frame on 2.2
    add_row(1'b1, 1'b1, 1'b1, `GAMMA_CODE_22, 1'b0, {6{16'h00FF}}, gamma_pkg::CURVE_2_2);
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_08, 1'b1, '0, gamma_pkg::CURVE_2_2);
    // Frame on 2.6
    add_row(1'b1, 1'b1, 1'b0, `GAMMA_CODE_26, 1'b1, '0, gamma_pkg::CURVE_2_6);
    add_row(1'b1, 1'b0, 1'b0, `GAMMA_CODE_16, 1'b1, '0, gamma_pkg::CURVE_2_6);
    add_gap(3);
    add_row(1'b1, 1'b0, 1'b1, `GAMMA_CODE_16, 1'b0, 96'h0B0A09080706050403020100,
            gamma_pkg::CURVE_2_6);
    // Code 13 has no curve of its own
    add_row(1'b1, 1'b1, 1'b0, 5'd13, 1'b1, '0, gamma_pkg::CURVE_2_2);
    add_row(1'b1, 1'b0, 1'b1, `GAMMA_CODE_08, 1'b1, '0, gamma_pkg::CURVE_2_2);
    add_row(1'b1, 1'b1, 1'b0, `GAMMA_CODE_08, 1'b0, {6{16'h00FF}}, gamma_pkg::CURVE_0_8);
    add_row(1'b1, 1'b0, 1'b1, `GAMMA_CODE_26, 1'b1, '0, gamma_pkg::CURVE_0_8);
  endtask

  // Drives one row and records what should leave the pipeline for it
  task automatic apply_row(input row_t row);
    logic [`GAMMA_DATA_W-1:0] data;
    beat_t                    beat;
    if (row.use_random) begin
      random_word(data);
    end else begin
      data = row.data;
    end
    in_valid   = row.valid;
    in_sof     = row.sof;
    in_eol     = row.eol;
    gamma_code = row.code;
    in_data    = data;
    beat.valid = row.valid;
    beat.sof   = row.sof;
    beat.eol   = row.eol;
    beat.data  = expected_word(row.curve, data);
    expect_q.push_back(beat);
  endtask

  // A beat driven before edge n is visible on the third falling edge after it
  task automatic next_cycle(input row_t row);
    @(negedge I_clk);
    if (expect_q.size() >= `GAMMA_LATENCY) begin
      check_beat(expect_q.pop_front());
    end
    apply_row(row);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    row_t idle;
    gamma_code = '0;
    in_valid   = 1'b0;
    in_sof     = 1'b0;
    in_eol     = 1'b0;
    in_data    = '0;
    lfsr_state = 16'd79;
    idle       = '{1'b0, 1'b0, 1'b0, `GAMMA_CODE_22, 1'b0, '0, gamma_pkg::CURVE_2_2};
    build_table();
    table_ready = 1'b1;

    @(posedge I_rst_n);
    repeat (2) begin
      @(negedge I_clk);
      check_reset_state();
    end

    foreach (rows[i]) begin
      next_cycle(rows[i]);
    end
    // Flush the last beats out of the pipeline
    repeat (`GAMMA_LATENCY + 1) begin
      next_cycle(idle);
    end

    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    wait (table_ready);
    #((rows.size() + `GAMMA_LATENCY + reset_cycles + 20) * clock_period);
    $display("Timeout: the test sequence did not finish in the time allowed");
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

endmodule
